/* verilog/irPkg.sv */
`default_nettype none

package irPkg;

	// Receiver phase
	typedef enum logic [1:0] {
		IR_IDLE     = 2'd0, // Waiting for the low leader
		IR_GUIDANCE = 2'd1, // Leader high
		IR_DATAREAD = 2'd2
	} irStateT;

	typedef logic [3:0][7:0] irFrameT; // Byte 2 is the command, byte 3 its inverse
	typedef logic [7:0]      keyCodeT;
	typedef logic [17:0]     irCountT;

	// Pulse thresholds in 50 MHz cycles
	localparam irCountT IR_IDLE_DUR          = 18'd230000; // 4.6 ms of leader low
	localparam irCountT IR_GUIDANCE_DUR      = 18'd210000; // 4.2 ms of leader high
	localparam irCountT IR_DATAREAD_DUR      = 18'd262143; // Longest high before abort
	localparam irCountT IR_DATA_HIGH_DUR     = 18'd41500;  // High past this is a one
	localparam irCountT IR_BIT_AVAILABLE_DUR = 18'd20000;  // Bit pointer step

endpackage

`default_nettype wire

/* verilog/gamePkg.sv */
`default_nettype none

package gamePkg;

	typedef enum logic [1:0] {
		CELL_EMPTY = 2'd0,
		CELL_P1    = 2'd1,
		CELL_P2    = 2'd2
	} cellT;

	// Index 0 is top left, row-major
	typedef cellT [8:0] boardT;

	typedef enum logic [1:0] {
		RES_PLAYING = 2'd0,
		RES_P1_WIN  = 2'd1,
		RES_P2_WIN  = 2'd2,
		RES_DRAW    = 2'd3
	} resultT;

	typedef enum logic [1:0] {
		GS_START  = 2'd0,
		GS_GAMING = 2'd1,
		GS_ENDING = 2'd2
	} gameStateT;

	typedef logic [3:0] moveCountT; // 0 to 9
	typedef logic [6:0] segT;       // Active low, bit 0 is segment a

	localparam boardT BOARD_EMPTY = '{default: CELL_EMPTY};

	// Remote keys
	localparam logic [7:0] KEY_START      = 8'h12;
	localparam logic [7:0] KEY_RESTART    = 8'h00;
	localparam logic [7:0] KEY_CELL_FIRST = 8'h01;
	localparam logic [7:0] KEY_CELL_LAST  = 8'h09;

endpackage

`default_nettype wire

/* verilog/irReceiver.sv */
`timescale 1ns/1ps
`default_nettype none

module irReceiver
	import irPkg::*;
#(
	parameter irCountT idleDur         = IR_IDLE_DUR,
	parameter irCountT guidanceDur     = IR_GUIDANCE_DUR,
	parameter irCountT dataReadDur     = IR_DATAREAD_DUR,
	parameter irCountT dataHighDur     = IR_DATA_HIGH_DUR,
	parameter irCountT bitAvailableDur = IR_BIT_AVAILABLE_DUR
) (
	input  wire     iCLK,
	input  wire     iRST_n,
	input  wire     iIRDA,
	output keyCodeT keyCode,
	output logic    keyValid
);

	irStateT    state;
	irCountT    idleCount;
	irCountT    guidanceCount;
	irCountT    dataCount;
	logic [5:0] bitCount; // 1 to 32 are data bits, 33 is the stop burst
	logic [4:0] bitPos;
	irFrameT    frame;
	logic       frameOk;

	assign bitPos  = 5'(bitCount - 6'd1);
	assign frameOk = (frame[3] == ~frame[2]);

	always_ff @(posedge iCLK or negedge iRST_n) begin
		if (!iRST_n) begin
			state <= IR_IDLE;
		end else begin
			case (state)
				IR_IDLE: begin
					if (idleCount > idleDur)
						state <= IR_GUIDANCE;
				end
				IR_GUIDANCE: begin
					if (guidanceCount > guidanceDur)
						state <= IR_DATAREAD;
				end
				IR_DATAREAD: begin
					// Too long a high means noise or a lost frame
					if (dataCount >= dataReadDur || bitCount == 6'd33)
						state <= IR_IDLE;
				end
				default: state <= IR_IDLE;
			endcase
		end
	end

	// Each counter runs only in its own phase and level
	always_ff @(posedge iCLK or negedge iRST_n) begin
		if (!iRST_n) begin
			idleCount     <= '0;
			guidanceCount <= '0;
			dataCount     <= '0;
		end else begin
			idleCount     <= (state == IR_IDLE && !iIRDA) ? idleCount + 1'b1 : '0;
			guidanceCount <= (state == IR_GUIDANCE && iIRDA) ? guidanceCount + 1'b1 : '0;
			dataCount     <= (state == IR_DATAREAD && iIRDA) ? dataCount + 1'b1 : '0;
		end
	end

	always_ff @(posedge iCLK or negedge iRST_n) begin
		if (!iRST_n)
			bitCount <= '0;
		else if (state != IR_DATAREAD)
			bitCount <= '0;
		else if (dataCount == bitAvailableDur)
			bitCount <= bitCount + 6'd1; // Once per high
	end

	// Bits only get set, so the frame is cleared outside data read
	always_ff @(posedge iCLK) begin
		if (state != IR_DATAREAD)
			frame <= '0;
		else if (dataCount >= dataHighDur && bitCount != '0 && bitCount <= 6'd32)
			frame[bitPos[4:3]][bitPos[2:0]] <= 1'b1; // Long high is a one
	end

	always_ff @(posedge iCLK or negedge iRST_n) begin
		if (!iRST_n) begin
			keyValid <= 1'b0;
			keyCode  <= '0;
		end else begin
			keyValid <= 1'b0;
			// Stop burst seen, report once
			if (state == IR_DATAREAD && bitCount == 6'd33 && frameOk) begin
				keyValid <= 1'b1;
				keyCode  <= frame[2];
			end
		end
	end

	// One report per frame
	assert property (@(posedge iCLK) disable iff (!iRST_n) keyValid |=> !keyValid);

endmodule

`default_nettype wire

/* verilog/winCheck.sv */
`timescale 1ns/1ps
`default_nettype none

module winCheck
	import gamePkg::*;
(
	input  wire boardT board,
	output resultT     result
);

	// Rows, then columns, then both diagonals
	localparam int lineCells [8][3] = '{
		'{0, 1, 2}, '{3, 4, 5}, '{6, 7, 8},
		'{0, 3, 6}, '{1, 4, 7}, '{2, 5, 8},
		'{0, 4, 8}, '{2, 4, 6}
	};

	logic p1Win;
	logic p2Win;
	logic boardFull;

	function automatic logic ownsLine(input boardT b, input int line, input cellT who);
		return b[lineCells[line][0]] == who
			&& b[lineCells[line][1]] == who
			&& b[lineCells[line][2]] == who;
	endfunction

	always_comb begin
		p1Win     = 1'b0;
		p2Win     = 1'b0;
		boardFull = 1'b1;
		for (int i = 0; i < 8; i++) begin
			p1Win |= ownsLine(board, i, CELL_P1);
			p2Win |= ownsLine(board, i, CELL_P2);
		end
		for (int c = 0; c < 9; c++) begin
			if (board[c] == CELL_EMPTY)
				boardFull = 1'b0;
		end
	end

	// Player one wins a tie of lines
	always_comb begin
		if (p1Win)
			result = RES_P1_WIN;
		else if (p2Win)
			result = RES_P2_WIN;
		else if (boardFull)
			result = RES_DRAW;
		else
			result = RES_PLAYING;
	end

endmodule

`default_nettype wire

/* verilog/gameControl.sv */
`timescale 1ns/1ps
`default_nettype none

module gameControl
	import irPkg::*;
	import gamePkg::*;
(
	input  wire           iCLK,
	input  wire           iRST_n,
	input  wire keyCodeT  keyCode,
	input  wire           keyValid,
	input  wire resultT   result,
	output boardT         board,
	output cellT          player,
	output moveCountT     moveCount,
	output gameStateT     gameState
);

	logic       cellKey;
	logic [3:0] cellIdx;

	assign cellKey = keyValid && keyCode >= KEY_CELL_FIRST && keyCode <= KEY_CELL_LAST;
	assign cellIdx = 4'(keyCode - KEY_CELL_FIRST); // Key 01 is cell 0

	always_ff @(posedge iCLK or negedge iRST_n) begin
		if (!iRST_n) begin
			gameState <= GS_START;
			board     <= BOARD_EMPTY;
			player    <= CELL_EMPTY;
			moveCount <= '0;
		end else begin
			case (gameState)
				GS_START: begin
					if (keyValid && keyCode == KEY_START) begin
						board     <= BOARD_EMPTY;
						player    <= CELL_P1; // Player one opens
						moveCount <= '0;
						gameState <= GS_GAMING;
					end
				end
				GS_GAMING: begin
					if (result != RES_PLAYING) begin
						gameState <= GS_ENDING; // Win or full board
						player    <= CELL_EMPTY;
					end else if (cellKey && board[cellIdx] == CELL_EMPTY) begin
						board[cellIdx] <= player;
						player         <= (player == CELL_P1) ? CELL_P2 : CELL_P1;
						moveCount      <= moveCount + 4'd1;
					end
				end
				GS_ENDING: begin
					// Board stays frozen for the result
					if (keyValid && keyCode == KEY_RESTART) begin
						gameState <= GS_START;
						board     <= BOARD_EMPTY;
						moveCount <= '0;
					end
				end
				default: gameState <= GS_START;
			endcase
		end
	end

	// The game must end before a tenth move
	assert property (@(posedge iCLK) disable iff (!iRST_n) moveCount <= 4'd9);

	assert property (@(posedge iCLK) disable iff (!iRST_n)
		gameState == GS_GAMING |-> player != CELL_EMPTY);

endmodule

`default_nettype wire

/* verilog/hexDisplay.sv */
`timescale 1ns/1ps
`default_nettype none

module hexDisplay
	import gamePkg::*;
(
	input  wire            iCLK,
	input  wire            iRST_n,
	input  wire gameStateT gameState,
	input  wire cellT      player,
	input  wire moveCountT moveCount,
	input  wire resultT    result,
	output segT            hex0,
	output segT            hex1,
	output segT            hex2,
	output segT            hex3
);

	// Standard hex font, segments gfedcba inverted
	function automatic segT hexSeg(input logic [3:0] value);
		case (value)
			4'h0: hexSeg = ~7'b0111111;
			4'h1: hexSeg = ~7'b0000110;
			4'h2: hexSeg = ~7'b1011011;
			4'h3: hexSeg = ~7'b1001111;
			4'h4: hexSeg = ~7'b1100110;
			4'h5: hexSeg = ~7'b1101101;
			4'h6: hexSeg = ~7'b1111101;
			4'h7: hexSeg = ~7'b0000111;
			4'h8: hexSeg = ~7'b1111111;
			4'h9: hexSeg = ~7'b1101111;
			4'hA: hexSeg = ~7'b1110111;
			4'hB: hexSeg = ~7'b1111100; // Lower case b
			4'hC: hexSeg = ~7'b1011000;
			4'hD: hexSeg = ~7'b1011110; // Lower case d
			4'hE: hexSeg = ~7'b1111001;
			default: hexSeg = ~7'b1110001; // F
		endcase
	endfunction

	always_ff @(posedge iCLK or negedge iRST_n) begin
		if (!iRST_n) begin
			hex0 <= hexSeg(4'h0);
			hex1 <= hexSeg(4'h0);
			hex2 <= hexSeg(4'h0);
			hex3 <= hexSeg(4'h0);
		end else begin
			hex0 <= hexSeg(moveCount);
			hex1 <= hexSeg({2'b00, result});
			hex2 <= hexSeg({2'b00, player});
			hex3 <= hexSeg({2'b00, gameState});
		end
	end

endmodule

`default_nettype wire

/* verilog/ticTacToeTop.sv */
`timescale 1ns/1ps
`default_nettype none

module ticTacToeTop
	import irPkg::*;
	import gamePkg::*;
#(
	parameter irCountT idleDur         = IR_IDLE_DUR,
	parameter irCountT guidanceDur     = IR_GUIDANCE_DUR,
	parameter irCountT dataReadDur     = IR_DATAREAD_DUR,
	parameter irCountT dataHighDur     = IR_DATA_HIGH_DUR,
	parameter irCountT bitAvailableDur = IR_BIT_AVAILABLE_DUR
) (
	input  wire       iCLK,
	input  wire       iRST_n,
	input  wire       iIRDA,
	output boardT     board,
	output resultT    result,
	output gameStateT gameState,
	output cellT      player,
	output keyCodeT   keyCode,  // Exported for observing the receiver
	output logic      keyValid,
	output segT       hex0,
	output segT       hex1,
	output segT       hex2,
	output segT       hex3
);

	moveCountT moveCount;

	irReceiver #(
		.idleDur(idleDur),
		.guidanceDur(guidanceDur),
		.dataReadDur(dataReadDur),
		.dataHighDur(dataHighDur),
		.bitAvailableDur(bitAvailableDur)
	) irReceiver_inst (
		.iCLK(iCLK),
		.iRST_n(iRST_n),
		.iIRDA(iIRDA),
		.keyCode(keyCode),
		.keyValid(keyValid)
	);

	gameControl gameControl_inst (
		.iCLK(iCLK),
		.iRST_n(iRST_n),
		.keyCode(keyCode),
		.keyValid(keyValid),
		.result(result),
		.board(board),
		.player(player),
		.moveCount(moveCount),
		.gameState(gameState)
	);

	winCheck winCheck_inst (
		.board(board),
		.result(result)
	);

	hexDisplay hexDisplay_inst (
		.iCLK(iCLK),
		.iRST_n(iRST_n),
		.gameState(gameState),
		.player(player),
		.moveCount(moveCount),
		.result(result),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3)
	);

endmodule

`default_nettype wire

/* bench/irFrameDriver.svh */
`ifndef IR_FRAME_DRIVER_SVH
`define IR_FRAME_DRIVER_SVH

// NEC pulse lengths in clock cycles, scaled like the receiver thresholds
localparam int LEADER_LOW  = 450;
localparam int LEADER_HIGH = 225;
localparam int BIT_LOW     = 28;
localparam int ZERO_HIGH   = 28;
localparam int ONE_HIGH    = 84;

// Galois LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
	if (s[0])
		return (s >> 1) ^ 32'h8020_0003;
	return s >> 1;
endfunction

function automatic int randomBits(input int n);
	int value;
	value = 0;
	for (int i = 0; i < n; i++) begin
		value = (value << 1) | lfsrState[0]; // One step per bit
		lfsrState = lfsrNext(lfsrState);
	end
	return value;
endfunction

task automatic holdLine(input logic level, input int cycles);
	for (int i = 0; i < cycles; i++) begin
		@(posedge iCLK);
		iIRDA <= level;
	end
endtask

// Address 00, its inverse, the key, then the key inverted
task automatic sendFrame(input keyCodeT keyByte, input logic badCheck);
	logic [31:0] bits;
	int          flipBit;
	bits = {~keyByte, keyByte, 8'hFF, 8'h00};
	if (badCheck) begin
		flipBit = 24 + randomBits(3);
		bits[flipBit] = ~bits[flipBit];
	end
	holdLine(1'b0, LEADER_LOW);
	holdLine(1'b1, LEADER_HIGH);
	for (int i = 0; i < 32; i++) begin
		holdLine(1'b0, BIT_LOW);
		holdLine(1'b1, bits[i] ? ONE_HIGH : ZERO_HIGH); // LSB first
	end
	holdLine(1'b0, BIT_LOW); // Stop burst
	holdLine(1'b1, 1);
endtask

`endif

/* bench/tbTicTacToe.sv */
`timescale 1ns/1ps
`default_nettype none

module tbTicTacToe
	import irPkg::*;
	import gamePkg::*;
();

	localparam int FIELDS        = 7;  // Words per stimulus line
	localparam int MAX_FRAMES    = 32;
	localparam int KEY_TIMEOUT   = 100; // Cycles after the stop burst
	localparam int SETTLE_CYCLES = 4;   // Controller, ending move and display register
	localparam logic [31:0] LFSR_SEED = 32'h7cc5_421b;

	// Lit segments gfedcba for digits F down to 0
	localparam logic [15:0][6:0] SEG_ON = {
		7'h71, 7'h79, 7'h5E, 7'h58, 7'h7C, 7'h77, 7'h6F, 7'h7F,
		7'h07, 7'h7D, 7'h6D, 7'h66, 7'h4F, 7'h5B, 7'h06, 7'h3F
	};

	logic      iCLK;
	logic      iRST_n;
	logic      iIRDA;
	boardT     board;
	resultT    result;
	gameStateT gameState;
	cellT      player;
	keyCodeT   keyCode;
	logic      keyValid;
	segT       hex0;
	segT       hex1;
	segT       hex2;
	segT       hex3;

	logic [31:0] lfsrState;
	logic [7:0]  stim [0:FIELDS*MAX_FRAMES-1];
	int          errors;
	int          errorsBefore;
	int          tests;
	int          base;
	keyCodeT     key;
	logic        corrupt;
	logic        seen;
	gameStateT   expState;
	resultT      expResult;
	moveCountT   expMoves;
	int          expCell;
	cellT        expValue;

	`include "irFrameDriver.svh"

	// Thresholds about a thousand times below the 50 MHz defaults
	ticTacToeTop #(
		.idleDur(18'd230),
		.guidanceDur(18'd210),
		.dataReadDur(18'd262),
		.dataHighDur(18'd41),
		.bitAvailableDur(18'd20)
	) ticTacToeTop_inst (
		.iCLK(iCLK),
		.iRST_n(iRST_n),
		.iIRDA(iIRDA),
		.board(board),
		.result(result),
		.gameState(gameState),
		.player(player),
		.keyCode(keyCode),
		.keyValid(keyValid),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3)
	);

	initial begin
		iCLK = 1'b0;
		forever #2 iCLK = ~iCLK;
	end

	function automatic segT segExpected(input logic [3:0] value);
		return ~SEG_ON[value];
	endfunction

	// Player to move follows the move count while gaming
	function automatic cellT playerExpected(input gameStateT s, input moveCountT moves);
		if (s != GS_GAMING)
			return CELL_EMPTY;
		return moves[0] ? CELL_P2 : CELL_P1;
	endfunction

	task automatic checkState(input gameStateT exp);
		if (gameState !== exp) begin
			$display("ERROR gameState: got %h expected %h", gameState, exp);
			errors++;
		end
	endtask

	task automatic checkResult(input resultT exp);
		if (result !== exp) begin
			$display("ERROR result: got %h expected %h", result, exp);
			errors++;
		end
	endtask

	task automatic checkPlayer(input cellT exp);
		if (player !== exp) begin
			$display("ERROR player: got %h expected %h", player, exp);
			errors++;
		end
	endtask

	// Index 9 stands for the whole board being empty
	task automatic checkBoard(input int idx, input cellT exp);
		for (int c = 0; c < 9; c++) begin
			if ((idx == 9 || idx == c) && board[c] !== ((idx == 9) ? CELL_EMPTY : exp)) begin
				$display("ERROR board[%0d]: got %h expected %h", c, board[c],
					(idx == 9) ? CELL_EMPTY : exp);
				errors++;
			end
		end
	endtask

	task automatic checkKey(input keyCodeT exp);
		if (keyCode !== exp) begin
			$display("ERROR keyCode: got %h expected %h", keyCode, exp);
			errors++;
		end
	endtask

	task automatic checkSeg(input string name, input segT got, input segT exp);
		if (got !== exp) begin
			$display("ERROR %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic checkAll();
		checkState(expState);
		checkResult(expResult);
		checkPlayer(playerExpected(expState, expMoves));
		checkBoard(expCell, expValue);
		checkSeg("hex0", hex0, segExpected(expMoves));
		checkSeg("hex1", hex1, segExpected({2'b00, expResult}));
		checkSeg("hex2", hex2, segExpected({2'b00, playerExpected(expState, expMoves)}));
		checkSeg("hex3", hex3, segExpected({2'b00, expState}));
	endtask

	task automatic waitKeyValid(output logic found);
		found = 1'b0;
		for (int i = 0; i < KEY_TIMEOUT && !found; i++) begin
			@(negedge iCLK);
			found = keyValid;
		end
	endtask

	initial begin
		iRST_n <= 1'b0;
		iIRDA  <= 1'b1; // Idle line is high
		lfsrState = LFSR_SEED;
		errors = 0;
		tests  = 0;
		$readmemh("bench/gameStimulus.txt", stim);
		repeat (4) @(posedge iCLK);
		iRST_n <= 1'b1;
		repeat (SETTLE_CYCLES) @(negedge iCLK);

		expState  = GS_START;
		expResult = RES_PLAYING;
		expMoves  = '0;
		expCell   = 9;
		expValue  = CELL_EMPTY;
		checkAll();
		tests++;
		$display("reset: %s", (errors == 0) ? "ok" : "failed");

		for (int f = 0; f < MAX_FRAMES && !$isunknown(stim[f*FIELDS]); f++) begin
			base         = f * FIELDS;
			key          = stim[base];
			corrupt      = stim[base+1][0];
			expState     = gameStateT'(stim[base+2][1:0]);
			expResult    = resultT'(stim[base+3][1:0]);
			expMoves     = stim[base+4][3:0];
			expCell      = stim[base+5];
			expValue     = cellT'(stim[base+6][1:0]);
			errorsBefore = errors;
			sendFrame(key, corrupt);
			waitKeyValid(seen);
			if (corrupt && seen) begin
				$display("Frame %0d with a bad check byte still gave a key pulse", f);
				errors++;
			end else if (!corrupt && !seen) begin
				$display("Frame %0d timed out waiting for a key pulse", f);
				errors++;
			end else if (seen) begin
				checkKey(key);
			end
			// A frame reports exactly once
			for (int i = 0; i < SETTLE_CYCLES; i++) begin
				@(negedge iCLK);
				if (keyValid) begin
					$display("Frame %0d gave keyValid again after its pulse", f);
					errors++;
				end
			end
			checkAll();
			tests++;
			$display("frame %0d key %h: %s", f, key, (errors == errorsBefore) ? "ok" : "failed");
			holdLine(1'b1, 40 + randomBits(6)); // Idle gap before the next frame
		end

		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/gameStimulus.txt */
// key corrupt gameState result moveCount cell value
// cell 09 means the whole board must be empty
05 0 0 0 0 09 0
12 1 0 0 0 09 0
12 0 1 0 0 09 0
05 0 1 0 1 04 1
05 0 1 0 1 04 1
0A 0 1 0 1 04 1
01 0 1 0 2 00 2
03 1 1 0 2 02 0
03 0 1 0 3 02 1
02 0 1 0 4 01 2
07 0 2 1 5 06 1
09 0 2 1 5 08 0
00 0 0 0 0 09 0
12 0 1 0 0 09 0
01 0 1 0 1 00 1
05 0 1 0 2 04 2
03 0 1 0 3 02 1
02 0 1 0 4 01 2
08 0 1 0 5 07 1
07 0 1 0 6 06 2
04 0 1 0 7 03 1
06 0 1 0 8 05 2
09 0 2 3 9 08 1
00 0 0 0 0 09 0

/* sources.f */
+incdir+bench
verilog/irPkg.sv
verilog/gamePkg.sv
verilog/irReceiver.sv
verilog/winCheck.sv
verilog/gameControl.sv
verilog/hexDisplay.sv
verilog/ticTacToeTop.sv
bench/tbTicTacToe.sv
